/* list.f */
cpu_pkg.sv
pipe_if.sv
inst_memory.sv
reg_file.sv
fetch_decode.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu -f list.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

/* tb_cpu.sv */
// pipelined core testbench
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

  localparam int HALT_TIMEOUT = 500;  // cycles from reset release
  localparam int PAD_WORDS    = 8;    // bubbles behind each program

  logic       clk;
  logic       reset;
  logic       imem_we;
  imem_addr_t imem_addr;
  word_t      imem_wdata;
  reg_addr_t  dbg_addr;
  word_t      dbg_data;
  logic       is_halted;

  word_t prog [$];
  word_t model_regs [32];
  word_t model_mem [int];
  int    seed;

  cpu_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data),
    .is_halted  (is_halted)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // instruction encoders
  function automatic word_t r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_R};
  endfunction

  function automatic word_t addi_word(input reg_addr_t rd, input reg_addr_t rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, F3_ADD_SUB, rd, OP_IMM};
  endfunction

  function automatic word_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, F3_WORD, rd, OP_LOAD};
  endfunction

  function automatic word_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t ecall_word();
    return {25'b0, OP_SYSTEM};
  endfunction

  task automatic step();
    @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic compare_logic(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic push_halt();
    prog.push_back(addi_word(HALT_REG, 5'd0, 12'd10));
    prog.push_back(ecall_word());
  endtask

  // program words, then bubbles so fetch never runs into stale code
  task automatic load_program();
    imem_addr_t a;
    imem_we = 1'b1;
    for (int k = 0; k < prog.size() + PAD_WORDS; k++) begin
      a = imem_addr_t'(k);
      imem_addr = a;
      if (k < prog.size()) begin
        imem_wdata = prog[k];
      end else begin
        imem_wdata = {a, a, a, 8'h00};  // opcode zero is a bubble
      end
      step();
    end
    imem_we = 1'b0;
  endtask

  // ISA level model, one instruction at a time
  task automatic run_model();
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      imm_i;
    word_t      imm_s;
    int         idx;
    int         pc;
    logic       done;
    logic       wr;
    reg_addr_t  rd;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    pc   = 0;
    done = 1'b0;
    while (!done) begin
      if (pc >= prog.size()) begin
        report_failure("reference model ran past the end of the program");
      end
      w     = prog[pc];
      rd    = w[11:7];
      a     = model_regs[w[19:15]];
      b     = model_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      wr    = 1'b1;
      res   = '0;
      case (w[6:0])
        OP_R: begin
          case (w[14:12])
            F3_ADD_SUB: res = w[30] ? a - b : a + b;
            F3_SLL:     res = a << b[4:0];
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_SRL:     res = a >> b[4:0];
            F3_OR:      res = a | b;
            F3_AND:     res = a & b;
            default:    report_failure("reference model met an unsupported funct3");
          endcase
        end
        OP_IMM: res = a + imm_i;
        OP_LOAD: begin
          idx = int'((a + imm_i) >> 2);
          if (!model_mem.exists(idx)) begin
            report_failure("program loads a word that was never stored");
          end
          res = model_mem[idx];
        end
        OP_STORE: begin
          model_mem[int'((a + imm_s) >> 2)] = b;
          wr = 1'b0;
        end
        OP_SYSTEM: begin
          wr   = 1'b0;
          done = (model_regs[HALT_REG] == HALT_CODE);
        end
        default: report_failure("reference model met an unknown opcode");
      endcase
      if (wr && rd != 5'd0) begin
        model_regs[rd] = res;
      end
      pc++;
    end
  endtask

  task automatic wait_halt(input string name);
    int cycles;
    cycles = 0;
    while (is_halted !== 1'b1) begin
      if (cycles == HALT_TIMEOUT) begin
        report_failure($sformatf("%s: processor never halted within %0d cycles",
                                 name, HALT_TIMEOUT));
      end
      step();
      cycles++;
    end
  endtask

  task automatic check_regs(input string name);
    for (int r = 0; r < 32; r++) begin
      dbg_addr = reg_addr_t'(r);
      @(negedge clk);  // debug read is combinational
      compare_word($sformatf("%s dbg_data x%0d", name, r), dbg_data, model_regs[r]);
      step();
    end
  endtask

  task automatic run_program(input string name);
    step();
    reset = 1'b1;
    load_program();
    repeat (5) step();
    reset = 1'b0;
    compare_logic("is_halted after reset", is_halted, 1'b0);
    wait_halt(name);
    run_model();
    check_regs(name);
  endtask

  task automatic test_forward_chain();
    prog.delete();
    prog.push_back(addi_word(5'd1, 5'd0, 12'd37));
    prog.push_back(addi_word(5'd2, 5'd1, 12'h5a5));
    prog.push_back(r_type_word(7'h00, F3_ADD_SUB, 5'd3, 5'd2, 5'd1));
    prog.push_back(r_type_word(7'h20, F3_ADD_SUB, 5'd4, 5'd3, 5'd1));
    prog.push_back(r_type_word(7'h00, F3_AND, 5'd5, 5'd4, 5'd3));
    prog.push_back(r_type_word(7'h00, F3_OR, 5'd6, 5'd5, 5'd4));
    prog.push_back(r_type_word(7'h00, F3_XOR, 5'd7, 5'd6, 5'd5));
    prog.push_back(r_type_word(7'h00, F3_SLL, 5'd8, 5'd7, 5'd1));  // shift by 5
    prog.push_back(r_type_word(7'h00, F3_SRL, 5'd9, 5'd8, 5'd2));
    prog.push_back(r_type_word(7'h00, F3_SLT, 5'd10, 5'd9, 5'd8));
    prog.push_back(addi_word(5'd11, 5'd10, 12'hffb));              // -5 plus result
    prog.push_back(r_type_word(7'h00, F3_SLT, 5'd12, 5'd11, 5'd10));
    push_halt();
    run_program("forward chain");
  endtask

  task automatic test_load_use();
    prog.delete();
    prog.push_back(addi_word(5'd1, 5'd0, 12'h040));
    prog.push_back(addi_word(5'd7, 5'd0, 12'd100));
    prog.push_back(addi_word(5'd2, 5'd0, 12'h123));
    prog.push_back(store_word(5'd2, 5'd1, 12'd8));  // data forwarded from addi
    prog.push_back(load_word(5'd5, 5'd1, 12'd8));
    prog.push_back(r_type_word(7'h00, F3_ADD_SUB, 5'd6, 5'd5, 5'd7));
    prog.push_back(r_type_word(7'h00, F3_ADD_SUB, 5'd8, 5'd6, 5'd5));
    push_halt();
    run_program("load use");
  endtask

  task automatic test_x0_writes();
    prog.delete();
    prog.push_back(addi_word(5'd0, 5'd0, 12'd55));
    prog.push_back(addi_word(5'd1, 5'd0, 12'd7));
    prog.push_back(r_type_word(7'h00, F3_ADD_SUB, 5'd0, 5'd1, 5'd1));
    prog.push_back(r_type_word(7'h00, F3_ADD_SUB, 5'd2, 5'd0, 5'd1));  // no x0 forward
    prog.push_back(addi_word(5'd3, 5'd0, 12'd0));
    push_halt();
    run_program("x0 writes");
  endtask

  task automatic test_ecall_halt();
    prog.delete();
    prog.push_back(addi_word(HALT_REG, 5'd0, 12'd3));
    prog.push_back(ecall_word());                    // not a halt code
    prog.push_back(addi_word(5'd5, 5'd0, 12'd11));
    push_halt();
    prog.push_back(addi_word(5'd6, 5'd0, 12'd99));   // must not retire
    prog.push_back(addi_word(5'd5, 5'd0, 12'd77));
    run_program("ecall halt");
    repeat (3) step();
    compare_logic("is_halted held", is_halted, 1'b1);
  endtask

  task automatic test_random_program();
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    prog.delete();
    for (int n = 0; n < 40; n++) begin
      kind = {$random(seed)} % 5;
      rd   = reg_addr_t'($random(seed));
      rs1  = reg_addr_t'($random(seed));
      rs2  = reg_addr_t'($random(seed));
      imm  = 12'($random(seed));
      case (kind)
        0: prog.push_back(addi_word(rd, rs1, imm));
        1: prog.push_back(r_type_word(7'h00, F3_ADD_SUB, rd, rs1, rs2));
        2: prog.push_back(r_type_word(7'h20, F3_ADD_SUB, rd, rs1, rs2));
        3: prog.push_back(r_type_word(7'h00, F3_XOR, rd, rs1, rs2));
        default: prog.push_back(r_type_word(7'h00, F3_SLL, rd, rs1, rs2));
      endcase
    end
    push_halt();
    run_program("random program");
  endtask

  initial begin
    seed       = 45;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    dbg_addr   = '0;
    test_forward_chain();
    test_load_use();
    test_x0_writes();
    test_ecall_halt();
    test_random_program();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* cpu_top.sv */
// pipelined rv32i subset core
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  word_t      imem_wdata,
  input  reg_addr_t  dbg_addr,
  output word_t      dbg_data,
  output logic       is_halted
);

  imem_addr_t fetch_addr;
  word_t      fetch_inst;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      x17_data;
  logic       wb_reg_write;
  reg_addr_t  wb_rd;
  word_t      wb_data;

  dec_ex_if u_dx ();
  ex_mem_if u_xm ();

  inst_memory u_imem (
    .clk        (clk),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .fetch_addr (fetch_addr),
    .fetch_inst (fetch_inst)
  );

  reg_file u_rf (
    .clk          (clk),
    .reset        (reset),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .x17_data     (x17_data),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  fetch_decode u_fd (
    .clk        (clk),
    .reset      (reset),
    .halted     (is_halted),
    .fetch_addr (fetch_addr),
    .fetch_inst (fetch_inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dx         (u_dx.dec)
  );

  execute_stage u_ex (
    .clk          (clk),
    .reset        (reset),
    .dx           (u_dx.ex),
    .xm           (u_xm.ex),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

  mem_wb_stage u_mw (
    .clk          (clk),
    .reset        (reset),
    .xm           (u_xm.mem),
    .x17_data     (x17_data),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .is_halted    (is_halted)
  );

endmodule

/* mem_wb_stage.sv */
// memory access, writeback and halt
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  ex_mem_if.mem     xm,
  input  word_t     x17_data,
  output logic      wb_reg_write,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      is_halted
);

  word_t               dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0]  dm_idx;
  word_t               load_data;
  ctrl_t               mw_ctrl;
  word_t               mw_load;
  word_t               mw_alu;
  logic                halt_now;

  assign dm_idx    = xm.alu_out[DMEM_AW+1:2];  // byte address to word index
  assign load_data = xm.ctrl.mem_read ? dmem[dm_idx] : '0;

  // older writes have all retired once the ecall sits here
  assign halt_now = mw_ctrl.is_ecall && (x17_data == HALT_CODE);

  always_ff @(posedge clk) begin
    if (xm.ctrl.mem_write && !halt_now && !is_halted) begin
      dmem[dm_idx] <= xm.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mw_ctrl   <= '0;
      is_halted <= 1'b0;
    end else begin
      mw_ctrl <= xm.ctrl;
      if (halt_now) begin
        is_halted <= 1'b1;  // sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    mw_load <= load_data;
    mw_alu  <= xm.alu_out;
    wb_rd   <= xm.rd;
  end

  assign wb_data      = mw_ctrl.mem_to_reg ? mw_load : mw_alu;
  assign wb_reg_write = mw_ctrl.reg_write && !is_halted;  // nothing retires after halt

endmodule

/* execute_stage.sv */
// execute stage with operand forwarding
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  dec_ex_if.ex      dx,
  ex_mem_if.ex      xm,
  input  logic      wb_reg_write,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data
);

  logic  mem_fwd_ok;
  logic  wb_fwd_ok;
  word_t op_a;
  word_t rs2_fwd;
  word_t op_b;
  word_t alu_res;

  assign mem_fwd_ok = xm.ctrl.reg_write && (xm.rd != '0);
  assign wb_fwd_ok  = wb_reg_write && (wb_rd != '0);

  // youngest producer wins
  always_comb begin
    if (mem_fwd_ok && xm.rd == dx.rs1) begin
      op_a = xm.alu_out;
    end else if (wb_fwd_ok && wb_rd == dx.rs1) begin
      op_a = wb_data;
    end else begin
      op_a = dx.rs1_data;
    end

    if (mem_fwd_ok && xm.rd == dx.rs2) begin
      rs2_fwd = xm.alu_out;
    end else if (wb_fwd_ok && wb_rd == dx.rs2) begin
      rs2_fwd = wb_data;
    end else begin
      rs2_fwd = dx.rs2_data;
    end
  end

  assign op_b = dx.ctrl.alu_src ? dx.imm : rs2_fwd;

  always_comb begin
    case (dx.ctrl.alu_op)
      ALU_ADD: alu_res = op_a + op_b;
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      ALU_SLL: alu_res = op_a << op_b[4:0];
      ALU_SRL: alu_res = op_a >> op_b[4:0];
      ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      default: alu_res = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      xm.ctrl <= '0;
    end else begin
      xm.ctrl <= dx.ctrl;
    end
  end

  always_ff @(posedge clk) begin
    xm.alu_out    <= alu_res;
    xm.store_data <= rs2_fwd;  // sw data after forwarding
    xm.rd         <= dx.rd;
  end

endmodule

/* fetch_decode.sv */
// fetch and decode stages
`timescale 1ns/1ps

module fetch_decode import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       halted,
  output imem_addr_t fetch_addr,
  input  word_t      fetch_inst,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  dec_ex_if.dec      dx
);

  imem_addr_t pc;
  inst_t      if_id;
  ctrl_t      dec_ctrl;
  word_t      dec_imm;
  logic       use_rs2;
  logic       load_use;
  logic       hold;

  assign fetch_addr = pc;
  assign rs1 = if_id.r.rs1;  // same bit position in every format
  assign rs2 = if_id.r.rs2;

  always_comb begin
    dec_ctrl = '0;
    dec_imm  = '0;
    use_rs2  = 1'b0;
    case (if_id.r.opcode)
      OP_R: begin
        use_rs2 = 1'b1;
        dec_ctrl.reg_write = 1'b1;
        case (if_id.r.funct3)
          F3_ADD_SUB: dec_ctrl.alu_op = if_id.r.funct7[5] ? ALU_SUB : ALU_ADD;
          F3_SLL:     dec_ctrl.alu_op = ALU_SLL;
          F3_SLT:     dec_ctrl.alu_op = ALU_SLT;
          F3_XOR:     dec_ctrl.alu_op = ALU_XOR;
          F3_SRL:     dec_ctrl.alu_op = ALU_SRL;
          F3_OR:      dec_ctrl.alu_op = ALU_OR;
          F3_AND:     dec_ctrl.alu_op = ALU_AND;
          default:    dec_ctrl = '0;  // sltu not supported
        endcase
      end
      OP_IMM: begin
        if (if_id.i.funct3 == F3_ADD_SUB) begin  // addi only
          dec_ctrl.alu_src   = 1'b1;
          dec_ctrl.reg_write = 1'b1;
        end
        dec_imm = {{20{if_id.i.imm[11]}}, if_id.i.imm};
      end
      OP_LOAD: begin
        dec_ctrl.alu_src    = 1'b1;
        dec_ctrl.mem_read   = 1'b1;
        dec_ctrl.mem_to_reg = 1'b1;
        dec_ctrl.reg_write  = 1'b1;
        dec_imm = {{20{if_id.i.imm[11]}}, if_id.i.imm};
      end
      OP_STORE: begin
        use_rs2 = 1'b1;
        dec_ctrl.alu_src   = 1'b1;
        dec_ctrl.mem_write = 1'b1;
        dec_imm = {{20{if_id.s.imm_hi[6]}}, if_id.s.imm_hi, if_id.s.imm_lo};
      end
      OP_SYSTEM: dec_ctrl.is_ecall = 1'b1;  // acted on in writeback
      default: ;                             // bubble
    endcase
  end

  // load in id/ex feeding the instruction being decoded
  assign load_use = dx.ctrl.mem_read && (dx.rd != '0) &&
                    ((dx.rd == rs1) || (use_rs2 && dx.rd == rs2));
  assign hold = load_use || halted;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= '0;
      if_id <= '0;  // opcode 0 decodes as a bubble
    end else if (!hold) begin
      pc    <= pc + 1'b1;
      if_id <= fetch_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || hold) begin
      dx.ctrl <= '0;
    end else begin
      dx.ctrl <= dec_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    dx.rs1_data <= rs1_data;
    dx.rs2_data <= rs2_data;
    dx.imm      <= dec_imm;
    dx.rs1      <= rs1;
    dx.rs2      <= use_rs2 ? rs2 : '0;  // i-type bits here are immediate
    dx.rd       <= if_id.r.rd;
  end

endmodule

/* reg_file.sv */
// integer register file
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      wb_reg_write,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output word_t     x17_data,
  input  reg_addr_t dbg_addr,
  output word_t     dbg_data
);

  word_t regs [32];
  logic  wr_en;

  assign wr_en = wb_reg_write && (wb_rd != '0);  // x0 stays zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // write-through so decode sees this cycle's writeback
  assign rs1_data = (wr_en && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (wr_en && wb_rd == rs2) ? wb_data : regs[rs2];

  assign x17_data = regs[HALT_REG];
  assign dbg_data = regs[dbg_addr];

endmodule

/* inst_memory.sv */
// instruction memory
`timescale 1ns/1ps

module inst_memory import cpu_pkg::*; (
  input  logic       clk,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  word_t      imem_wdata,
  input  imem_addr_t fetch_addr,
  output word_t      fetch_inst
);

  word_t mem [IMEM_WORDS];

  // program load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (imem_we) begin
      mem[imem_addr] <= imem_wdata;
    end
  end

  assign fetch_inst = mem[fetch_addr];  // async read, same cycle as pc

endmodule

/* pipe_if.sv */
// pipeline stage interfaces
`timescale 1ns/1ps

// outputs of the id/ex register
interface dec_ex_if import cpu_pkg::*; ();
  ctrl_t     ctrl;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;

  modport dec (output ctrl, rs1_data, rs2_data, imm, rs1, rs2, rd);
  modport ex  (input  ctrl, rs1_data, rs2_data, imm, rs1, rs2, rd);
endinterface

// outputs of the ex/mem register
interface ex_mem_if import cpu_pkg::*; ();
  ctrl_t     ctrl;
  word_t     alu_out;
  word_t     store_data;
  reg_addr_t rd;

  modport ex  (output ctrl, alu_out, store_data, rd);
  modport mem (input  ctrl, alu_out, store_data, rd);
endinterface

/* cpu_pkg.sv */
// rv32i subset processor definitions
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  typedef logic [IMEM_AW-1:0] imem_addr_t;  // word index, not byte address

  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 codes for register and immediate arithmetic
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010;  // lw / sw width

  localparam reg_addr_t HALT_REG  = 5'd17;  // a7
  localparam word_t     HALT_CODE = 32'd10;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,  // zero so a bubble decodes as add
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src;     // second operand from immediate
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    reg_write;
    logic    is_ecall;
  } ctrl_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // one instruction word, viewed by format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
  } inst_t;

endpackage
